/* source/level_pkg.sv */
package level_pkg;

	typedef enum logic [1:0] {
		LEVEL_1,
		LEVEL_2,
		LEVEL_3,
		LEVEL_4
	} level_e;

	typedef enum logic [1:0] {
		LV_START,	// announce level, load config
		LV_PLAY,	// wait for all birds down
		LV_CLEARED	// pause before next level
	} level_state_e;

	typedef struct packed {
		logic [1:0] tree_speed;
		logic [1:0] bird_speed;
		logic [2:0] trees;	// trees deployed over the level
		logic two_birds;	// 0: bird 0 only
		logic [6:0] time_bonus;	// seconds
	} level_cfg_t;

	// one entry per level_e, difficulty rising
	localparam level_cfg_t LEVEL_TABLE [0:3] = '{
		'{tree_speed: 2'd1, bird_speed: 2'd1, trees: 3'd2, two_birds: 1'b0,
			time_bonus: 7'd20},
		'{tree_speed: 2'd1, bird_speed: 2'd2, trees: 3'd3, two_birds: 1'b1,
			time_bonus: 7'd25},
		'{tree_speed: 2'd2, bird_speed: 2'd2, trees: 3'd5, two_birds: 1'b1,
			time_bonus: 7'd30},
		'{tree_speed: 2'd3, bird_speed: 2'd3, trees: 3'd7, two_birds: 1'b1,
			time_bonus: 7'd40}
	};

endpackage

/* source/game_types_pkg.sv */
package game_types_pkg;

	localparam int NUM_SHOTS = 8;	// shot object slots
	localparam int NUM_TREES = 8;	// tree object slots

	localparam logic [1:0] MAX_LIVES = 2'd3;

	// one-cycle deploy strobes, one bit per slot
	typedef struct packed {
		logic [NUM_SHOTS-1:0] shot;
		logic [NUM_TREES-1:0] tree;
		logic [1:0] bird;
	} deploy_t;

	typedef struct packed {
		logic [1:0] tree_speed;
		logic [1:0] bird_speed;
	} speed_t;

	typedef struct packed {
		logic red;	// invincible after a hit
		logic active;	// low once game over
		logic [1:0] lives;
	} player_t;

endpackage

/* source/frame_timer.sv */
`timescale 1ns/1ns

module frame_timer #(
	parameter int FRAME_CYCLES = 833_333
) (
	input logic clk,
	input logic resetN,
	output logic start_of_frame
);
	localparam int CNT_W = (FRAME_CYCLES > 2) ? $clog2(FRAME_CYCLES) : 1;

	logic [CNT_W-1:0] cycle_cnt;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			cycle_cnt <= '0;
			start_of_frame <= 1'b0;
		end else if (cycle_cnt == CNT_W'(FRAME_CYCLES - 1)) begin
			cycle_cnt <= '0;	// wrap, one pulse per frame
			start_of_frame <= 1'b1;
		end else begin
			cycle_cnt <= cycle_cnt + 1'b1;
			start_of_frame <= 1'b0;
		end
	end

	a_sof_single: assert property (@(posedge clk) disable iff (!resetN)
		start_of_frame |=> !start_of_frame);

endmodule

/* source/hit_detector.sv */
`timescale 1ns/1ns

module hit_detector (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input logic collision,	// raw player/tree overlap
	output logic hit
);
	logic seen;	// sticky over the current frame

	// a frame runs from one pulse up to the cycle before the next one,
	// so a collision in the pulse cycle starts the new frame's flag
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			seen <= 1'b0;
			hit <= 1'b0;
		end else if (start_of_frame) begin
			hit <= seen;	// report the frame just ended
			seen <= collision;
		end else begin
			hit <= 1'b0;
			seen <= seen | collision;
		end
	end

endmodule

/* source/level_fsm.sv */
`timescale 1ns/1ns

module level_fsm
	import level_pkg::*, game_types_pkg::*;
#(
	parameter int LEVEL_PAUSE = 32
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input logic [1:0] birds_alive,
	input player_t player,
	output logic start_level,
	output level_cfg_t cfg,
	output speed_t speeds,
	output logic add_time,
	output logic [6:0] time_bonus
);
	localparam int PAUSE_W = (LEVEL_PAUSE > 1) ? $clog2(LEVEL_PAUSE + 1) : 1;

	level_state_e state;
	level_e level;
	logic [PAUSE_W-1:0] pause;	// frames left before next level

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= LV_START;
			level <= LEVEL_1;
			pause <= '0;
			start_level <= 1'b0;
			add_time <= 1'b0;
			time_bonus <= '0;
			cfg <= LEVEL_TABLE[LEVEL_1];
		end else begin
			start_level <= 1'b0;
			add_time <= 1'b0;
			time_bonus <= '0;
			if (start_of_frame) begin
				case (state)
					LV_START: begin
						start_level <= 1'b1;
						cfg <= LEVEL_TABLE[level];	// same cycle as start_level
						state <= LV_PLAY;
					end
					LV_PLAY: begin
						// game over freezes the level here
						if (birds_alive == 2'b00 && player.active) begin
							add_time <= 1'b1;
							time_bonus <= LEVEL_TABLE[level].time_bonus;
							pause <= PAUSE_W'(LEVEL_PAUSE);
							state <= LV_CLEARED;
						end
					end
					LV_CLEARED: begin
						if (pause <= 1) begin
							if (level != LEVEL_4)
								level <= level_e'(level + 2'd1);
							state <= LV_START;
						end else begin
							pause <= pause - 1'b1;
						end
					end
					default: state <= LV_START;
				endcase
			end
		end
	end

	assign speeds = '{tree_speed: cfg.tree_speed, bird_speed: cfg.bird_speed};

	a_no_start_and_bonus: assert property (@(posedge clk) disable iff (!resetN)
		!(start_level && add_time));

	a_level_saturates: assert property (@(posedge clk) disable iff (!resetN)
		level == LEVEL_4 |=> level == LEVEL_4);

endmodule

/* source/game_controller.sv */
`timescale 1ns/1ns

module game_controller
	import level_pkg::*, game_types_pkg::*;
#(
	parameter int SHOT_COOLDOWN = 10,
	parameter int TREE_WAIT = 40,
	parameter int RED_FRAMES = 64
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input logic start_level,	// from level_fsm, cfg valid with it
	input logic hit,	// at most one per frame
	input logic shoot,
	input logic god_mode,
	input level_cfg_t cfg,
	output deploy_t deploy,
	output player_t player
);
	localparam int SHOT_W = $clog2(NUM_SHOTS);
	localparam int TREE_W = $clog2(NUM_TREES);
	localparam int CD_W = (SHOT_COOLDOWN > 1) ? $clog2(SHOT_COOLDOWN + 1) : 1;
	localparam int WAIT_W = (TREE_WAIT > 2) ? $clog2(TREE_WAIT) : 1;
	localparam int RED_W = (RED_FRAMES > 1) ? $clog2(RED_FRAMES + 1) : 1;

	logic [NUM_SHOTS-1:0] shot_strobe;
	logic [NUM_TREES-1:0] tree_strobe;
	logic [1:0] bird_strobe;

	logic [SHOT_W-1:0] shot_slot;	// next shot slot
	logic [CD_W-1:0] cooldown;	// frames until next shot allowed
	logic [TREE_W-1:0] tree_slot;	// next tree slot
	logic [WAIT_W-1:0] tree_frame;	// frames since last tree slot
	logic [2:0] trees_left;
	logic [RED_W-1:0] red_cnt;
	logic [1:0] lives;
	logic active;
	logic invincible;

	assign invincible = (red_cnt != '0) || god_mode;

	// shots, round robin with cooldown
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			shot_strobe <= '0;
			shot_slot <= '0;
			cooldown <= '0;
		end else begin
			shot_strobe <= '0;
			if (start_of_frame) begin
				if (shoot && active && cooldown == '0) begin
					shot_strobe[shot_slot] <= 1'b1;
					shot_slot <= (shot_slot == SHOT_W'(NUM_SHOTS - 1)) ?
						'0 : shot_slot + 1'b1;
					cooldown <= CD_W'(SHOT_COOLDOWN);
				end else if (cooldown != '0) begin
					cooldown <= cooldown - 1'b1;
				end
			end
		end
	end

	// trees, one every TREE_WAIT frames while the level has some left
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			tree_strobe <= '0;
			tree_slot <= '0;
			tree_frame <= '0;
			trees_left <= '0;
		end else begin
			tree_strobe <= '0;
			if (start_level) begin
				trees_left <= cfg.trees;
				tree_frame <= '0;	// restart spacing each level
			end else if (start_of_frame && active) begin
				if (tree_frame == WAIT_W'(TREE_WAIT - 1)) begin
					tree_frame <= '0;
					if (trees_left != '0) begin
						tree_strobe[tree_slot] <= 1'b1;
						tree_slot <= (tree_slot == TREE_W'(NUM_TREES - 1)) ?
							'0 : tree_slot + 1'b1;
						trees_left <= trees_left - 1'b1;
					end
				end else begin
					tree_frame <= tree_frame + 1'b1;
				end
			end
		end
	end

	// birds go out one cycle after the level start
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			bird_strobe <= 2'b00;
		else if (start_level)
			bird_strobe <= {cfg.two_birds, 1'b1};	// bird 0 always
		else
			bird_strobe <= 2'b00;
	end

	// lives and invincibility window
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lives <= MAX_LIVES;
			active <= 1'b1;
			red_cnt <= '0;
		end else if (hit && active && !invincible) begin
			if (lives > 2'd1) begin
				lives <= lives - 2'd1;
				red_cnt <= RED_W'(RED_FRAMES);
			end else begin
				lives <= 2'd0;	// last life gone
				active <= 1'b0;
			end
		end else if (start_of_frame && red_cnt != '0) begin
			red_cnt <= red_cnt - 1'b1;
		end
	end

	assign deploy = '{shot: shot_strobe, tree: tree_strobe, bird: bird_strobe};
	assign player = '{red: (red_cnt != '0), active: active, lives: lives};

	a_one_shot: assert property (@(posedge clk) disable iff (!resetN)
		$onehot0(deploy.shot));

	a_one_tree: assert property (@(posedge clk) disable iff (!resetN)
		$onehot0(deploy.tree));

endmodule

/* source/game_top.sv */
`timescale 1ns/1ns

module game_top
	import level_pkg::*, game_types_pkg::*;
#(
	parameter int FRAME_CYCLES = 833_333,	// 25 MHz at 30 frames/s
	parameter int SHOT_COOLDOWN = 10,
	parameter int TREE_WAIT = 40,
	parameter int RED_FRAMES = 64,
	parameter int LEVEL_PAUSE = 32
) (
	input logic clk,
	input logic resetN,
	input logic shoot,
	input logic god_mode,
	input logic collision,
	input logic [1:0] birds_alive,
	output deploy_t deploy,
	output speed_t speeds,
	output player_t player,
	output logic add_time,
	output logic [6:0] time_bonus
);
	logic start_of_frame;
	logic hit;
	logic start_level;
	level_cfg_t cfg;

	frame_timer #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) i_frame_timer (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame)
	);

	hit_detector i_hit_detector (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.collision(collision),
		.hit(hit)
	);

	level_fsm #(
		.LEVEL_PAUSE(LEVEL_PAUSE)
	) i_level_fsm (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.birds_alive(birds_alive),
		.player(player),	// freezes play at game over
		.start_level(start_level),
		.cfg(cfg),
		.speeds(speeds),
		.add_time(add_time),
		.time_bonus(time_bonus)
	);

	game_controller #(
		.SHOT_COOLDOWN(SHOT_COOLDOWN),
		.TREE_WAIT(TREE_WAIT),
		.RED_FRAMES(RED_FRAMES)
	) i_game_controller (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.start_level(start_level),
		.hit(hit),
		.shoot(shoot),
		.god_mode(god_mode),
		.cfg(cfg),
		.deploy(deploy),
		.player(player)
	);

endmodule

/* tests/game_model.svh */
`ifndef GAME_MODEL_SVH
`define GAME_MODEL_SVH

// cycle model of the frame rules, stepped once per clock
level_state_e m_state;
level_e m_level;
level_cfg_t m_cfg;
int m_pause;
int m_cooldown;	// frames before the next shot
int m_shot_slot;
int m_tree_slot;
int m_tree_frame;	// frame pulses since the last tree slot
int m_trees_left;
int m_red_cnt;
logic [1:0] m_lives;
logic m_active;
logic m_seen;	// collision within the running frame
logic m_hit;
logic m_start;

// expected DUT outputs for the next cycle
deploy_t exp_deploy;
speed_t exp_speeds;
player_t exp_player;
logic exp_add_time;
logic [6:0] exp_time_bonus;

task automatic reset_model();
	m_state = LV_START;
	m_level = LEVEL_1;
	m_cfg = LEVEL_TABLE[LEVEL_1];
	m_pause = 0;
	m_cooldown = 0;
	m_shot_slot = 0;
	m_tree_slot = 0;
	m_tree_frame = 0;
	m_trees_left = 0;
	m_red_cnt = 0;
	m_lives = 2'd3;
	m_active = 1'b1;
	m_seen = 1'b0;
	m_hit = 1'b0;
	m_start = 1'b0;
	exp_deploy = '0;
	exp_speeds = '{tree_speed: m_cfg.tree_speed, bird_speed: m_cfg.bird_speed};
	exp_player = '{red: 1'b0, active: 1'b1, lives: 2'd3};
	exp_add_time = 1'b0;
	exp_time_bonus = '0;
endtask

// sof and the inputs are the values seen in the current cycle
task automatic step_model(input logic sof, input logic coll, input logic shoot_in,
		input logic god_in, input logic [1:0] birds_in);
	logic start_next;
	start_next = 1'b0;
	exp_deploy = '0;
	exp_add_time = 1'b0;
	exp_time_bonus = '0;
	if (sof && shoot_in && m_active && m_cooldown == 0) begin
		exp_deploy.shot = NUM_SHOTS'(1) << m_shot_slot;
		m_shot_slot = (m_shot_slot + 1) % NUM_SHOTS;
		m_cooldown = SHOT_COOLDOWN;
	end else if (sof && m_cooldown > 0) begin
		m_cooldown--;
	end
	if (m_start) begin
		m_trees_left = int'(m_cfg.trees);
		m_tree_frame = 0;
		exp_deploy.bird = {m_cfg.two_birds, 1'b1};	// bird 0 in every level
	end else if (sof && m_active) begin
		m_tree_frame++;
		if (m_tree_frame == TREE_WAIT) begin
			m_tree_frame = 0;
			if (m_trees_left > 0) begin
				exp_deploy.tree = NUM_TREES'(1) << m_tree_slot;
				m_tree_slot = (m_tree_slot + 1) % NUM_TREES;
				m_trees_left--;
			end
		end
	end
	if (sof) begin
		case (m_state)
			LV_START: begin
				start_next = 1'b1;
				m_cfg = LEVEL_TABLE[m_level];
				m_state = LV_PLAY;
			end
			LV_PLAY: begin
				if (birds_in == 2'b00 && m_active) begin
					exp_add_time = 1'b1;
					exp_time_bonus = LEVEL_TABLE[m_level].time_bonus;
					m_pause = LEVEL_PAUSE;
					m_state = LV_CLEARED;
				end
			end
			LV_CLEARED: begin
				if (m_pause <= 1) begin
					if (m_level != LEVEL_4)
						m_level = m_level.next();	// stays at the last level
					m_state = LV_START;
				end else begin
					m_pause--;
				end
			end
		endcase
	end
	if (m_hit && m_active && m_red_cnt == 0 && !god_in) begin
		if (m_lives > 2'd1) begin
			m_lives = m_lives - 2'd1;
			m_red_cnt = RED_FRAMES;
		end else begin
			m_lives = 2'd0;	// game over
			m_active = 1'b0;
		end
	end else if (sof && m_red_cnt > 0) begin
		m_red_cnt--;
	end
	m_hit = sof ? m_seen : 1'b0;
	m_seen = sof ? coll : (m_seen | coll);
	m_start = start_next;
	exp_speeds = '{tree_speed: m_cfg.tree_speed, bird_speed: m_cfg.bird_speed};
	exp_player = '{red: (m_red_cnt != 0), active: m_active, lives: m_lives};
endtask

`endif

/* tests/game_top_tb.sv */
`timescale 1ns/1ns

module game_top_tb
	import level_pkg::*, game_types_pkg::*;
#(
	parameter int FRAME_CYCLES = 8,
	parameter int SHOT_COOLDOWN = 3,
	parameter int TREE_WAIT = 4,
	parameter int RED_FRAMES = 5,
	parameter int LEVEL_PAUSE = 2
);
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 4;
	localparam int RUN_FRAMES = 200;
	localparam int WATCHDOG_FRAMES = 250;
	localparam int LATE_FRAME = 150;	// more collisions, god mode off
	localparam int SEED = 32'h1a92_a3fd;

	logic clk;
	logic resetN;
	logic shoot;
	logic god_mode;
	logic collision;
	logic [1:0] birds_alive;
	deploy_t deploy;
	speed_t speeds;
	player_t player;
	logic add_time;
	logic [6:0] time_bonus;

	int error_count;
	int check_count;
	int level_frames;	// frame pulses since the last bird deploy
	int level_len;	// birds_alive drops to zero after this many frames
	int trees_seen;
	int levels_cleared;

	`include "game_model.svh"

	game_top #(
		.FRAME_CYCLES(FRAME_CYCLES),
		.SHOT_COOLDOWN(SHOT_COOLDOWN),
		.TREE_WAIT(TREE_WAIT),
		.RED_FRAMES(RED_FRAMES),
		.LEVEL_PAUSE(LEVEL_PAUSE)
	) i_game_top (
		.clk(clk),
		.resetN(resetN),
		.shoot(shoot),
		.god_mode(god_mode),
		.collision(collision),
		.birds_alive(birds_alive),
		.deploy(deploy),
		.speeds(speeds),
		.player(player),
		.add_time(add_time),
		.time_bonus(time_bonus)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_FRAMES * FRAME_CYCLES * CLK_PERIOD);
		$display("watchdog timeout, the run did not reach its end");
		$display("SOME TESTS FAILED");
		$finish;
	end

	task automatic compare_field(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t ns %s expected 0x%0h got 0x%0h", $time, name,
				expected, actual);
		end
	endtask

	task automatic check_outputs();
		compare_field("deploy", 32'(exp_deploy), 32'(deploy));
		compare_field("speeds", 32'(exp_speeds), 32'(speeds));
		compare_field("player", 32'(exp_player), 32'(player));
		compare_field("add_time", 32'(exp_add_time), 32'(add_time));
		compare_field("time_bonus", 32'(exp_time_bonus), 32'(time_bonus));
	endtask

	// inputs are held for a frame, collision is redrawn each cycle
	task automatic drive_inputs(input int cyc);
		int frame;
		int coll_limit;
		frame = cyc / FRAME_CYCLES;
		coll_limit = (frame < LATE_FRAME) ? 1 : 20;	// per 200 cycles
		collision <= ($urandom_range(0, 199) < coll_limit);
		if (cyc % FRAME_CYCLES == FRAME_CYCLES / 2) begin
			shoot <= ($urandom_range(0, 1) == 1);
			god_mode <= (frame < LATE_FRAME) && ($urandom_range(0, 3) != 0);
			birds_alive <= (level_frames >= level_len) ? 2'b00 : 2'($urandom_range(1, 3));
		end
	endtask

	task automatic track_level(input logic sof);
		if (sof)
			level_frames++;
		if (deploy.tree != '0)
			trees_seen++;
		if (deploy.bird != 2'b00) begin
			trees_seen = 0;
			level_frames = 0;
			level_len = int'($urandom_range(10, 30));
			if (level_len <= TREE_WAIT * int'(LEVEL_TABLE[m_level].trees))
				level_len = TREE_WAIT * int'(LEVEL_TABLE[m_level].trees) + 1;	// all trees out
		end
		if (add_time) begin
			levels_cleared++;
			if (trees_seen != int'(LEVEL_TABLE[m_level].trees)) begin
				error_count++;
				$display("level %0d was cleared after %0d trees, its table entry has %0d",
					int'(m_level) + 1, trees_seen, LEVEL_TABLE[m_level].trees);
			end
		end
	endtask

	initial begin
		logic sof;
		void'($urandom(SEED));
		resetN = 1'b0;
		shoot = 1'b0;
		god_mode = 1'b0;
		collision = 1'b0;
		birds_alive = 2'b11;
		error_count = 0;
		check_count = 0;
		level_frames = 0;
		level_len = 1000;	// no clear before the first level start
		trees_seen = 0;
		levels_cleared = 0;
		reset_model();
		repeat (RESET_CYCLES) @(posedge clk);
		resetN <= 1'b1;
		for (int cyc = 1; cyc <= RUN_FRAMES * FRAME_CYCLES; cyc++) begin
			@(posedge clk);
			drive_inputs(cyc);
			@(negedge clk);
			sof = (cyc % FRAME_CYCLES == 0);	// frame pulse seen in this cycle
			check_outputs();
			track_level(sof);
			step_model(sof, collision, shoot, god_mode, birds_alive);
		end
		if (levels_cleared == 0) begin
			error_count++;
			$display("no level was cleared during the whole run");
		end
		$display("summary: %0d checks, %0d errors, %0d levels cleared",
			check_count, error_count, levels_cleared);
		if (error_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* bird_hunt.f */
+incdir+tests
source/level_pkg.sv
source/game_types_pkg.sv
source/frame_timer.sv
source/hit_detector.sv
source/level_fsm.sv
source/game_controller.sv
source/game_top.sv
tests/game_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the game_top testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --top-module game_top_tb -f bird_hunt.f \
	&& ./obj_dir/Vgame_top_tb > "$LOG" 2>&1 \
	|| { echo "build or simulation error"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"
grep -q "ALL TESTS PASSED" "$LOG" && echo "result: pass" || { echo "result: fail"; exit 1; }
